/* common/seg_pkg.sv */
//////////////////////////////////////////////////
// Seven-segment display shared types
//////////////////////////////////////////////////

package seg_pkg;

    // Display geometry and timing, in clock cycles
    localparam int NUM_DIGITS  = 4;
    localparam int SEC_TICKS   = 20;    // Board build sets the real clock rate here
    localparam int SCAN_TICKS  = 4;
    localparam int QUEUE_DEPTH = 4;

    // Derived widths
    localparam int SEC_W   = $clog2(SEC_TICKS);
    localparam int SCAN_W  = $clog2(SCAN_TICKS);
    localparam int DIGIT_W = $clog2(NUM_DIGITS);
    localparam int QPTR_W  = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W  = $clog2(QUEUE_DEPTH + 1);

    // How the message text is read
    typedef enum logic {
        MODE_HEX,
        MODE_ASCII
    } disp_mode_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SHOW
    } disp_state_t;

    // Segments a..g, active low
    typedef logic [0:6] seg_t;

    localparam seg_t SEG_BLANK = 7'b1111111;

    // One queued message
    typedef struct packed {
        disp_mode_t  mode;
        logic [31:0] text;      // Hex uses [15:0], digit 3 most significant
        logic [2:0]  num_sec;   // 1 to 7
    } msg_t;

endpackage

/* source/mod_counter.sv */
//////////////////////////////////////////////////
// Wrapping counter
//////////////////////////////////////////////////

`timescale 1ns/1ns

module mod_counter #(
    parameter int WIDTH = 7,
    parameter int MAX   = 127
) (
    input  logic             clk,
    input  logic             arst,
    input  logic             clear,
    output logic [WIDTH-1:0] q,
    output logic             wrap
);

    localparam logic [WIDTH-1:0] MAX_Q = WIDTH'(MAX);

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
            q <= '0;
        else if (clear || q == MAX_Q)
            q <= '0;
        else
            q <= q + 1'b1;
    end

    assign wrap = (q == MAX_Q);   // Terminal count

    a_q_in_range: assert property (@(posedge clk) disable iff (arst) q <= MAX_Q)
        else $error("mod_counter: q above MAX");

endmodule

/* display/glyph_decode.sv */
//////////////////////////////////////////////////
// Seven-segment glyph decoder
//////////////////////////////////////////////////

`timescale 1ns/1ns

module glyph_decode (
    input  seg_pkg::disp_mode_t mode,
    input  logic [7:0]          code,
    output seg_pkg::seg_t       seg
);

    // Standard hex patterns, b and d in lower case
    function automatic seg_pkg::seg_t hex_glyph(input logic [3:0] nib);
        seg_pkg::seg_t g;
        case (nib)
            4'h0: g = 7'b0000001;
            4'h1: g = 7'b1001111;
            4'h2: g = 7'b0010010;
            4'h3: g = 7'b0000110;
            4'h4: g = 7'b1001100;
            4'h5: g = 7'b0100100;
            4'h6: g = 7'b0100000;
            4'h7: g = 7'b0001111;
            4'h8: g = 7'b0000000;
            4'h9: g = 7'b0000100;
            4'hA: g = 7'b0001000;
            4'hB: g = 7'b1100000;
            4'hC: g = 7'b0110001;
            4'hD: g = 7'b1000010;
            4'hE: g = 7'b0110000;
            default: g = 7'b0111000;  // F
        endcase
        return g;
    endfunction

    always_comb
    begin
        if (mode == seg_pkg::MODE_HEX)
        begin
            seg = hex_glyph(code[3:0]);
        end
        else
        begin
            case (code)
                "0", "1", "2", "3", "4",
                "5", "6", "7", "8", "9": seg = hex_glyph(code[3:0]);
                "A", "B", "C", "D", "E",
                "F": seg = hex_glyph(code[3:0] + 4'd9);   // 'A' is 0x41
                "G": seg = 7'b0100001;
                "H": seg = 7'b1001000;
                "I": seg = 7'b1001111;
                "J": seg = 7'b1000011;
                "L": seg = 7'b1110001;
                "N": seg = 7'b1101010;  // Lower-case n
                "O": seg = 7'b0000001;
                "P": seg = 7'b0011000;
                "Q": seg = 7'b0001100;  // Lower-case q
                "R": seg = 7'b1111010;  // Lower-case r
                "S": seg = 7'b0100100;
                "T": seg = 7'b1110000;  // Lower-case t
                "U": seg = 7'b1000001;
                "Y": seg = 7'b1000100;
                "-": seg = 7'b1111110;
                // K, M, V, W, X, Z, space and the rest have no form
                default: seg = seg_pkg::SEG_BLANK;
            endcase
        end
    end

endmodule

/* display/digit_scan.sv */
//////////////////////////////////////////////////
// Digit multiplexer
//////////////////////////////////////////////////

`timescale 1ns/1ns

module digit_scan (
    input  logic                            clk,
    input  logic                            arst,
    input  logic                            showing,
    input  seg_pkg::msg_t                   cur,
    output seg_pkg::seg_t                   seg,
    output logic [seg_pkg::NUM_DIGITS-1:0]  an
);

    logic [seg_pkg::DIGIT_W-1:0] idx;
    logic                        scan_wrap;
    logic [7:0]                  code;
    seg_pkg::seg_t               glyph;

    // Held at zero until showing rises, so digit 0 gets a full slot first
    mod_counter #(
        .WIDTH (seg_pkg::SCAN_W),
        .MAX   (seg_pkg::SCAN_TICKS - 1)
    ) u_scan_cnt (
        .clk   (clk),
        .arst  (arst),
        .clear (!showing),
        .q     (),
        .wrap  (scan_wrap)
    );

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
            idx <= '0;
        else if (!showing)
            idx <= '0;
        else if (scan_wrap)
            idx <= idx + 1'b1;   // 0, 1, 2, 3, then back
    end

    // Pick this digit's nibble or character
    always_comb
    begin
        if (cur.mode == seg_pkg::MODE_HEX)
            code = {4'h0, cur.text[idx * 4 +: 4]};
        else
            code = cur.text[idx * 8 +: 8];
    end

    glyph_decode u_glyph (
        .mode (cur.mode),
        .code (code),
        .seg  (glyph)
    );

    // seg and an share one register stage
    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            seg <= seg_pkg::SEG_BLANK;
            an  <= '1;
        end
        else if (!showing)
        begin
            seg <= seg_pkg::SEG_BLANK;
            an  <= '1;
        end
        else
        begin
            seg <= glyph;
            an  <= ~(seg_pkg::NUM_DIGITS'(1) << idx);
        end
    end

    a_one_anode: assert property (@(posedge clk) disable iff (arst) $onehot0(~an))
        else $error("digit_scan: more than one anode active");

endmodule

/* display/timed_display.sv */
//////////////////////////////////////////////////
// Timed message display control
//////////////////////////////////////////////////

`timescale 1ns/1ns

module timed_display (
    input  logic          clk,
    input  logic          arst,
    input  logic          empty,
    input  seg_pkg::msg_t head,
    output logic          pop,
    output seg_pkg::msg_t cur,
    output logic          showing,
    output logic          done
);

    seg_pkg::disp_state_t state;
    logic [2:0]           secs_left;
    logic                 tick;

    // One tick per second of ST_SHOW, restarted for each message
    mod_counter #(
        .WIDTH (seg_pkg::SEC_W),
        .MAX   (seg_pkg::SEC_TICKS - 1)
    ) u_sec_cnt (
        .clk   (clk),
        .arst  (arst),
        .clear (state != seg_pkg::ST_SHOW),
        .q     (),
        .wrap  (tick)
    );

    assign pop     = (state == seg_pkg::ST_IDLE) && !empty;
    assign showing = (state == seg_pkg::ST_SHOW);
    // Zero seconds is treated as one
    assign done    = showing && tick && (secs_left <= 3'd1);

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            state     <= seg_pkg::ST_IDLE;
            secs_left <= '0;
        end
        else
        begin
            case (state)
                seg_pkg::ST_IDLE:
                    if (pop)
                        state <= seg_pkg::ST_LOAD;
                seg_pkg::ST_LOAD:
                begin
                    secs_left <= cur.num_sec;
                    state     <= seg_pkg::ST_SHOW;
                end
                seg_pkg::ST_SHOW:
                begin
                    if (done)
                        state <= seg_pkg::ST_IDLE;
                    else if (tick)
                        secs_left <= secs_left - 1'b1;
                end
                default: state <= seg_pkg::ST_IDLE;
            endcase
        end
    end

    // The queue drops its head on the pop edge, so take the copy then
    always_ff @(posedge clk)
    begin
        if (pop)
            cur <= head;
    end

    a_pop_valid: assert property (@(posedge clk) disable iff (arst) pop |-> !empty)
        else $error("timed_display: pop without a queued message");

endmodule

/* source/msg_queue.sv */
//////////////////////////////////////////////////
// Message FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ns

module msg_queue (
    input  logic          clk,
    input  logic          arst,
    input  logic          push,
    input  seg_pkg::msg_t wdata,
    input  logic          pop,
    output seg_pkg::msg_t head,
    output logic          empty,
    output logic          full
);

    seg_pkg::msg_t               mem [seg_pkg::QUEUE_DEPTH];
    logic [seg_pkg::QPTR_W-1:0]  wr_ptr;
    logic [seg_pkg::QPTR_W-1:0]  rd_ptr;
    logic [seg_pkg::QCNT_W-1:0]  count;
    logic                        do_push;
    logic                        do_pop;

    localparam logic [seg_pkg::QPTR_W-1:0] LAST_PTR = seg_pkg::QPTR_W'(seg_pkg::QUEUE_DEPTH - 1);

    assign empty   = (count == '0);
    assign full    = (count == seg_pkg::QCNT_W'(seg_pkg::QUEUE_DEPTH));
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);   // Full but popping frees a slot
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            // Count moves only when exactly one side acts
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (arst)
        count <= seg_pkg::QCNT_W'(seg_pkg::QUEUE_DEPTH))
        else $error("msg_queue: count above depth");

endmodule

/* source/seg_display_top.sv */
//////////////////////////////////////////////////
// Seven-segment message display top
//////////////////////////////////////////////////

`timescale 1ns/1ns

module seg_display_top (
    input  logic                            clk,
    input  logic                            arst,
    input  logic                            push,
    input  seg_pkg::msg_t                   msg,
    output logic                            full,
    output logic                            busy,
    output logic                            done,
    output seg_pkg::seg_t                   seg,
    output logic [seg_pkg::NUM_DIGITS-1:0]  an
);

    seg_pkg::msg_t head;
    seg_pkg::msg_t cur;
    logic          empty;
    logic          pop;
    logic          showing;

    msg_queue u_queue (
        .clk   (clk),
        .arst  (arst),
        .push  (push),
        .wdata (msg),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (full)
    );

    timed_display u_timed (
        .clk     (clk),
        .arst    (arst),
        .empty   (empty),
        .head    (head),
        .pop     (pop),
        .cur     (cur),
        .showing (showing),
        .done    (done)
    );

    digit_scan u_scan (
        .clk     (clk),
        .arst    (arst),
        .showing (showing),
        .cur     (cur),
        .seg     (seg),
        .an      (an)
    );

    assign busy = showing;

endmodule

/* sim/tb_seg_display.sv */
//////////////////////////////////////////////////
// Seven-segment display testbench
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_seg_display;

    localparam int MAX_VEC = 16;
    localparam int MAX_GAP = 10;

    logic          clk;
    logic          arst;
    logic          push;
    seg_pkg::msg_t msg;
    logic          full;
    logic          busy;
    logic          done;
    seg_pkg::seg_t seg;
    logic [3:0]    an;

    // Vectors from the data file
    logic        v_mode [MAX_VEC];
    logic [31:0] v_text [MAX_VEC];
    logic [2:0]  v_sec  [MAX_VEC];
    logic [6:0]  v_seg  [MAX_VEC][4];
    int          num_vec;

    int  cyc;
    int  errors;
    int  tests_pass;
    int  tests_fail;
    int  seed;
    int  budget;
    bit  budget_ready;
    int  shown_q[$];     // Accepted messages still to be displayed
    int  cur_idx;
    bit  prev_active;
    bit  prev_done;
    logic [3:0] digits_seen;   // Digits lit during the current message

    seg_display_top dut (
        .clk  (clk),
        .arst (arst),
        .push (push),
        .msg  (msg),
        .full (full),
        .busy (busy),
        .done (done),
        .seg  (seg),
        .an   (an)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    // Glyph and done-width monitor, sampled away from the active edge
    always @(negedge clk)
    begin
        if (!arst)
        begin
            if (done && prev_done)
            begin
                $display("ERROR: done stayed high for more than one cycle");
                errors++;
            end
            if (an != 4'hF && !prev_active)
            begin
                digits_seen = 4'h0;
                if (shown_q.size() == 0)
                begin
                    $display("ERROR: display lit with no queued message");
                    errors++;
                    cur_idx = -1;
                end
                else
                    cur_idx = shown_q.pop_front();
            end
            if (an != 4'hF && cur_idx >= 0)
                check_glyph();
            if (an == 4'hF && prev_active && cur_idx >= 0 && digits_seen != 4'hF)
            begin
                $display("ERROR: message %0d went dark before every digit was lit", cur_idx);
                errors++;
            end
            prev_active = (an != 4'hF);
            prev_done   = done;
        end
    end

    task automatic check_glyph();
        int k;
        k = -1;
        for (int i = 0; i < 4; i++)
            if (an == ~(4'b0001 << i))
                k = i;
        if (k < 0)
        begin
            $display("ERROR: anode pattern %h has not exactly one digit on", an);
            errors++;
        end
        else
        begin
            digits_seen[k] = 1'b1;
            if (seg != v_seg[cur_idx][k])
            begin
                $display("FAIL seg digit %0d msg %0d expected %h actual %h",
                         k, cur_idx, v_seg[cur_idx][k], seg);
                errors++;
            end
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        int    m;
        int    t;
        int    s;
        int    g0;
        int    g1;
        int    g2;
        int    g3;
        fd = $fopen("sim/seg_display_input.txt", "r");
        if (fd == 0)
        begin
            $display("ERROR: could not open the vector file");
            errors++;
            return;
        end
        while (!$feof(fd) && num_vec < MAX_VEC)
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#")
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", m, t, s, g0, g1, g2, g3);
                if (n == 7)
                begin
                    v_mode[num_vec]   = m[0];
                    v_text[num_vec]   = t;
                    v_sec[num_vec]    = s[2:0];
                    v_seg[num_vec][0] = g0[6:0];
                    v_seg[num_vec][1] = g1[6:0];
                    v_seg[num_vec][2] = g2[6:0];
                    v_seg[num_vec][3] = g3[6:0];
                    num_vec++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Ends on the negedge after the edge that samples push
    task automatic push_msg(input int i, input bit accept, output int push_cyc);
        @(posedge clk);
        push <= 1'b1;
        msg  <= '{mode: seg_pkg::disp_mode_t'(v_mode[i]), text: v_text[i],
                  num_sec: v_sec[i]};
        if (accept)
            shown_q.push_back(i);
        @(posedge clk);
        push <= 1'b0;
        @(negedge clk);
        push_cyc = cyc;
    endtask

    task automatic wait_done(output int done_cyc);
        int n;
        n = 0;
        done_cyc = -1;
        @(negedge clk);
        while (!done && n < 200)
        begin
            @(negedge clk);
            n++;
        end
        if (done)
            done_cyc = cyc;
        else
        begin
            $display("ERROR: done never came");
            errors++;
        end
    endtask

    task automatic check_delta(input string what, input int got, input int exp_d);
        if (got != exp_d)
        begin
            $display("FAIL %s expected %h actual %h", what, exp_d, got);
            errors++;
        end
    endtask

    // Display stays dark with busy low
    task automatic check_idle(input int cycles);
        @(negedge clk);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            if (busy !== 1'b0)
            begin
                $display("FAIL busy expected 0 actual %h", busy);
                errors++;
            end
            if (an !== 4'hF)
            begin
                $display("FAIL an expected f actual %h", an);
                errors++;
            end
            if (seg !== seg_pkg::SEG_BLANK)
            begin
                $display("FAIL seg expected 7f actual %h", seg);
                errors++;
            end
        end
    endtask

    task automatic check_reset_state();
        if (an !== 4'hF || seg !== seg_pkg::SEG_BLANK)
        begin
            $display("FAIL an/seg expected f/7f actual %h/%h", an, seg);
            errors++;
        end
        if (done !== 1'b0 || busy !== 1'b0 || full !== 1'b0)
        begin
            $display("FAIL done/busy/full expected 0/0/0 actual %h/%h/%h",
                     done, busy, full);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            $display("test %s: ok", name);
            tests_pass++;
        end
        else
        begin
            $display("test %s: %0d errors", name, errors - err_before);
            tests_fail++;
        end
    endtask

    // Single pushes into an empty queue, one file range
    task automatic run_singles(input string name, input int first, input int last);
        int e0;
        int pc;
        int dc;
        int gap;
        e0 = errors;
        for (int i = first; i <= last; i++)
        begin
            push_msg(i, 1'b1, pc);
            wait_done(dc);
            check_delta("done latency", dc + 1 - pc, v_sec[i] * seg_pkg::SEC_TICKS + 2);
            gap = 3 + ($unsigned($random(seed)) % MAX_GAP);
            check_idle(gap);
        end
        end_test(name, e0);
    endtask

    initial
    begin
        int e0;
        int pc;
        int dc;
        int last_dc;
        int total;
        clk          = 1'b0;
        arst         = 1'b1;
        push         = 1'b0;
        msg          = '0;
        cyc          = 0;
        errors       = 0;
        tests_pass   = 0;
        tests_fail   = 0;
        seed         = 10939;
        num_vec      = 0;
        cur_idx      = -1;
        prev_active  = 1'b0;
        prev_done    = 1'b0;
        digits_seen  = 4'h0;
        budget_ready = 1'b0;

        load_vectors();
        total = 0;
        for (int i = 0; i < num_vec; i++)
            total += v_sec[i] * seg_pkg::SEC_TICKS + 2 + MAX_GAP + 3;
        budget       = 2 * (2 * total + 100);
        budget_ready = 1'b1;

        e0 = errors;
        repeat (8)
        begin
            @(negedge clk);
            check_reset_state();
            @(posedge clk);
        end
        arst <= 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            check_reset_state();
        end
        end_test("reset", e0);

        run_singles("hex", 0, 2);
        run_singles("ascii", 3, 5);

        // Queue fill while one message shows, then back-to-back dones
        e0 = errors;
        push_msg(0, 1'b1, pc);
        while (!busy)
            @(negedge clk);
        for (int i = 1; i <= 4; i++)
            push_msg(i, 1'b1, dc);
        if (full !== 1'b1)
        begin
            $display("FAIL full expected 1 actual %h", full);
            errors++;
        end
        push_msg(5, 1'b0, dc);   // Dropped
        wait_done(last_dc);
        check_delta("done latency", last_dc + 1 - pc, v_sec[0] * seg_pkg::SEC_TICKS + 2);
        for (int i = 1; i <= 4; i++)
        begin
            wait_done(dc);
            check_delta("done spacing", dc - last_dc, v_sec[i] * seg_pkg::SEC_TICKS + 2);
            last_dc = dc;
        end
        check_idle(2 * seg_pkg::SEC_TICKS);
        if (shown_q.size() != 0)
        begin
            $display("ERROR: queued messages were never displayed");
            errors++;
        end
        end_test("queue", e0);

        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (errors == 0 && num_vec == 6)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // Watchdog sized from the message lengths
    initial
    begin
        wait (budget_ready);
        repeat (budget) @(posedge clk);
        $display("ERROR: run timed out before all tests finished");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* sim/seg_display_input.txt */
# Columns: mode (0 hex, 1 ascii), text, num_sec, then expected seg codes
# (a..g, active low, a is the top bit) for digits 0, 1, 2 and 3
0 00001234 1 4c 06 12 4f
0 0000abcd 2 42 31 60 08
0 00009e0f 1 38 01 30 04
1 48454c50 2 18 71 30 48
1 2d4b7a31 1 4f 7f 7f 7e
1 20554e53 1 24 6a 41 7f

/* list.f */
common/seg_pkg.sv
source/mod_counter.sv
display/glyph_decode.sv
display/digit_scan.sv
display/timed_display.sv
source/msg_queue.sv
source/seg_display_top.sv
sim/tb_seg_display.sv

/* run.sh */
#!/bin/sh
# Build and run the seven-segment display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_seg_display -f list.f -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx ">>> PASS"; then
    exit 0
else
    exit 1
fi
